// File: design/apb_io_regs.sv
`default_nettype none

module apb_io_regs import board_io_pkg::*;
(
    input  logic                    clk,
    input  logic                    arst_n,

    input  logic [APB_ADDR_W  -1:0] paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [APB_DATA_W  -1:0] pwdata,
    output logic [APB_DATA_W  -1:0] prdata,
    output logic                    pready,
    output logic                    pslverr,

    input  logic [NUM_SWITCHES-1:0] sw_db,
    input  logic [NUM_BUTTONS -1:0] btn_db,

    output logic [15:0]             led,
    output disp_word_u              disp_data,
    output logic                    raw_mode,
    output logic [NUM_DIGITS  -1:0] digit_en
);

    logic                   access;
    logic                   wr_en;
    logic                   mapped;
    logic                   read_only;
    logic [NUM_BUTTONS-1:0] btn_prev;
    logic [NUM_BUTTONS-1:0] pressed;
    logic [NUM_BUTTONS-1:0] press_rise;
    logic [NUM_BUTTONS-1:0] press_clr;

    assign access = psel & penable;                     // zero wait states, so this ends the transfer.
    assign wr_en  = access & pwrite;

    assign pready = 1'b1;

    // read mux and address decode.
    always_comb begin
        prdata    = '0;
        mapped    = 1'b1;
        read_only = 1'b0;
        case (paddr)
            REG_SWITCHES: begin
                prdata[NUM_SWITCHES-1:0] = sw_db;
                read_only                = 1'b1;
            end
            REG_BUTTONS: begin
                prdata[NUM_BUTTONS-1:0] = btn_db;
                read_only               = 1'b1;
            end
            REG_PRESSED:   prdata[NUM_BUTTONS-1:0] = pressed;
            REG_LEDS:      prdata[15:0]            = led;
            REG_DISP_CTRL: prdata[15:0]            = { digit_en, 7'b0, raw_mode };
            REG_DISP_DATA: prdata                  = disp_data;
            default:       mapped                  = 1'b0;
        endcase
    end

    assign pslverr = access & (~mapped | (pwrite & read_only));

    // rising edges of the debounced buttons set the sticky bits.
    assign press_rise = btn_db & ~btn_prev;
    assign press_clr  = (wr_en && paddr == REG_PRESSED) ? pwdata[NUM_BUTTONS-1:0] : '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            btn_prev <= '0;
            pressed  <= '0;
        end else begin
            btn_prev <= btn_db;
            pressed  <= (pressed & ~press_clr) | press_rise;   // a new press beats the clear.
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            led       <= '0;
            raw_mode  <= 1'b0;
            digit_en  <= '1;                            // all digits enabled out of reset.
            disp_data <= '0;
        end else if (wr_en) begin
            case (paddr)
                REG_LEDS: led <= pwdata[15:0];
                REG_DISP_CTRL: begin
                    raw_mode <= pwdata[0];
                    digit_en <= pwdata[15:8];
                end
                REG_DISP_DATA: disp_data <= pwdata;
                default: ;                              // read-only and unmapped writes are dropped.
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/board_io_pkg.sv
`default_nettype none

package board_io_pkg;

    localparam int NUM_SWITCHES = 16;
    localparam int NUM_BUTTONS  = 5;
    localparam int NUM_DIGITS   = 8;
    localparam int NUM_INPUTS   = NUM_SWITCHES + NUM_BUTTONS;   // debounced as one vector.

    localparam int RAW_DIGITS   = 4;                             // digits covered by raw mode.
    localparam int DIGIT_W      = $clog2(NUM_DIGITS);
    localparam int RAW_IDX_W    = $clog2(RAW_DIGITS);

    // a board build raises this to about a million.
    localparam int DEBOUNCE_CYCLES = 4;
    localparam int DEB_CNT_W       = $clog2(DEBOUNCE_CYCLES + 1);

    // a board build raises this to about 100000.
    localparam int SCAN_CYCLES = 8;
    localparam int SCAN_CNT_W  = $clog2(SCAN_CYCLES + 1);

    localparam int APB_ADDR_W = 8;
    localparam int APB_DATA_W = 32;

    localparam logic [APB_ADDR_W-1:0] REG_SWITCHES  = 8'h00;   // read-only.
    localparam logic [APB_ADDR_W-1:0] REG_BUTTONS   = 8'h04;   // read-only.
    localparam logic [APB_ADDR_W-1:0] REG_PRESSED   = 8'h08;   // write 1 to clear.
    localparam logic [APB_ADDR_W-1:0] REG_LEDS      = 8'h0C;
    localparam logic [APB_ADDR_W-1:0] REG_DISP_CTRL = 8'h10;
    localparam logic [APB_ADDR_W-1:0] REG_DISP_DATA = 8'h14;

    // The display word is read either as eight hex nibbles or as four
    // raw segment bytes. In a raw byte bit 7 is the dot and bits 6:0 are
    // segments g down to a, with 1 meaning lit.
    typedef union packed {
        logic [NUM_DIGITS-1:0][3:0] hex;   // digit 0 is the lowest nibble.
        logic [RAW_DIGITS-1:0][7:0] raw;   // digit 0 is the lowest byte.
    } disp_word_u;

endpackage

`default_nettype wire

// File: design/board_io_top.sv
`default_nettype none

module board_io_top import board_io_pkg::*;
(
    input  logic                    clk,
    input  logic                    arst_n,

    input  logic [APB_ADDR_W  -1:0] paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [APB_DATA_W  -1:0] pwdata,
    output logic [APB_DATA_W  -1:0] prdata,
    output logic                    pready,
    output logic                    pslverr,

    input  logic [NUM_SWITCHES-1:0] sw,
    input  logic [NUM_BUTTONS -1:0] btn,

    output logic [15:0]             led,
    output logic [6:0]              seg,       // active low, g down to a.
    output logic                    dp,
    output logic [NUM_DIGITS  -1:0] an
);

    logic [NUM_SWITCHES-1:0] sw_db;
    logic [NUM_BUTTONS -1:0] btn_db;
    disp_word_u              disp_data;
    logic                    raw_mode;
    logic [NUM_DIGITS  -1:0] digit_en;

    input_debouncer input_debouncer
    (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .sw        ( sw        ),
        .btn       ( btn       ),
        .sw_db     ( sw_db     ),
        .btn_db    ( btn_db    )
    );

    apb_io_regs apb_io_regs
    (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .paddr     ( paddr     ),
        .psel      ( psel      ),
        .penable   ( penable   ),
        .pwrite    ( pwrite    ),
        .pwdata    ( pwdata    ),
        .prdata    ( prdata    ),
        .pready    ( pready    ),
        .pslverr   ( pslverr   ),
        .sw_db     ( sw_db     ),
        .btn_db    ( btn_db    ),
        .led       ( led       ),
        .disp_data ( disp_data ),
        .raw_mode  ( raw_mode  ),
        .digit_en  ( digit_en  )
    );

    seven_seg_scanner seven_seg_scanner
    (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .disp_data ( disp_data ),
        .raw_mode  ( raw_mode  ),
        .digit_en  ( digit_en  ),
        .seg       ( seg       ),
        .dp        ( dp        ),
        .an        ( an        )
    );

endmodule

`default_nettype wire

// File: design/input_debouncer.sv
`default_nettype none

module input_debouncer import board_io_pkg::*;
(
    input  logic                    clk,
    input  logic                    arst_n,

    input  logic [NUM_SWITCHES-1:0] sw,
    input  logic [NUM_BUTTONS -1:0] btn,

    output logic [NUM_SWITCHES-1:0] sw_db,
    output logic [NUM_BUTTONS -1:0] btn_db
);

    logic [NUM_INPUTS-1:0] raw_in;
    logic [NUM_INPUTS-1:0] sync_q1;
    logic [NUM_INPUTS-1:0] sync_q2;
    logic [NUM_INPUTS-1:0] stable;

    assign raw_in = { btn, sw };

    // two-flop synchronizer for every board input.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= raw_in;
            sync_q2 <= sync_q1;
        end
    end

    // Each bit counts consecutive cycles in which the synchronized value
    // differs from the debounced one, and flips after DEBOUNCE_CYCLES of them.
    for (genvar i = 0; i < NUM_INPUTS; i++) begin : g_bit
        logic [DEB_CNT_W-1:0] count;

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                count     <= '0;
                stable[i] <= 1'b0;
            end else if (sync_q2[i] == stable[i]) begin
                count     <= '0;                           // any bounce restarts the wait.
            end else if (count == DEB_CNT_W'(DEBOUNCE_CYCLES - 1)) begin
                count     <= '0;
                stable[i] <= sync_q2[i];
            end else begin
                count     <= count + 1'b1;
            end
        end
    end

    assign sw_db  = stable[NUM_SWITCHES-1:0];
    assign btn_db = stable[NUM_INPUTS-1:NUM_SWITCHES];

endmodule

`default_nettype wire

// File: design/seven_seg_scanner.sv
`default_nettype none

module seven_seg_scanner import board_io_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,

    input  disp_word_u            disp_data,
    input  logic                  raw_mode,
    input  logic [NUM_DIGITS-1:0] digit_en,

    output logic [6:0]            seg,
    output logic                  dp,
    output logic [NUM_DIGITS-1:0] an
);

    logic [SCAN_CNT_W-1:0] prescale;
    logic                  scan_tick;
    logic [DIGIT_W   -1:0] digit_idx;
    logic [6:0]            pattern;
    logic                  dot;
    logic                  blank;
    logic [NUM_DIGITS-1:0] anode_sel;

    function automatic logic [6:0] hex_to_seg(input logic [3:0] nibble);
        case (nibble)
            4'h0:    return 7'h3F;
            4'h1:    return 7'h06;
            4'h2:    return 7'h5B;
            4'h3:    return 7'h4F;
            4'h4:    return 7'h66;
            4'h5:    return 7'h6D;
            4'h6:    return 7'h7D;
            4'h7:    return 7'h07;
            4'h8:    return 7'h7F;
            4'h9:    return 7'h6F;
            4'hA:    return 7'h77;
            4'hB:    return 7'h7C;
            4'hC:    return 7'h39;
            4'hD:    return 7'h5E;
            4'hE:    return 7'h79;
            default: return 7'h71;
        endcase
    endfunction

    assign scan_tick = (prescale == SCAN_CNT_W'(SCAN_CYCLES - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prescale  <= '0;
            digit_idx <= '0;
        end else if (scan_tick) begin
            prescale  <= '0;
            if (digit_idx == DIGIT_W'(NUM_DIGITS - 1))
                digit_idx <= '0;
            else
                digit_idx <= digit_idx + 1'b1;
        end else begin
            prescale  <= prescale + 1'b1;
        end
    end

    // pattern for the selected digit, active high.
    always_comb begin
        pattern = '0;
        dot     = 1'b0;
        blank   = 1'b0;
        if (raw_mode) begin
            if (digit_idx < DIGIT_W'(RAW_DIGITS))
                { dot, pattern } = disp_data.raw[digit_idx[RAW_IDX_W-1:0]];
            else
                blank = 1'b1;                           // upper digits stay dark in raw mode.
        end else begin
            pattern = hex_to_seg(disp_data.hex[digit_idx]);
        end
    end

    assign anode_sel = (digit_en[digit_idx] && !blank) ? (NUM_DIGITS'(1) << digit_idx) : '0;

    // segments, dot and anodes change on the same edge.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            seg <= '1;
            dp  <= 1'b1;
            an  <= '1;
        end else begin
            seg <= ~pattern;
            dp  <= ~dot;
            an  <= ~anode_sel;
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module board_io_tb -Mdir obj_dir -o board_io_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/board_io_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the run passes only if the testbench printed its pass line.
if printf '%s\n' "$output" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1

// File: testbench/board_io_assert.sv
`default_nettype none

module board_io_assert import board_io_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic                  pready,
    input  logic                  pslverr,
    input  logic [15:0]           led,
    input  logic [NUM_DIGITS-1:0] an
);

    logic led_write;

    assign led_write = psel && penable && pwrite && (paddr == REG_LEDS);

    // the scanner drives one digit at a time.
    one_anode: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(~an))
        else $error("more than one anode low: %b", an);

    reset_dark: assert property (@(posedge clk) !arst_n |=> (arst_n || an == '1))
        else $error("anodes driven during reset: %b", an);

    ready_high: assert property (@(posedge clk) disable iff (!arst_n) pready)
        else $error("pready dropped");

    err_in_access: assert property (@(posedge clk) disable iff (!arst_n)
        pslverr |-> (psel && penable))
        else $error("pslverr high outside an access cycle");

    // a write lands on the edge that ends the access cycle.
    led_on_write: assert property (@(posedge clk) disable iff (!arst_n)
        (led != $past(led)) |-> $past(led_write))
        else $error("led changed without a write to the led register");

endmodule

bind board_io_top board_io_assert board_io_checks
(
    .clk     ( clk     ),
    .arst_n  ( arst_n  ),
    .paddr   ( paddr   ),
    .psel    ( psel    ),
    .penable ( penable ),
    .pwrite  ( pwrite  ),
    .pready  ( pready  ),
    .pslverr ( pslverr ),
    .led     ( led     ),
    .an      ( an      )
);

`default_nettype wire

// File: testbench/board_io_tb.sv
`default_nettype none

module board_io_tb import board_io_pkg::*; ();

    localparam int          CLK_PERIOD  = 40;
    localparam int          HOLD_CYCLES = DEBOUNCE_CYCLES + 4;
    localparam int          NUM_TESTS   = 6;
    localparam int          TEST_CYCLES = NUM_DIGITS * SCAN_CYCLES + 4 * (DEBOUNCE_CYCLES + 2);
    localparam int          WATCHDOG_CYCLES = NUM_TESTS * TEST_CYCLES + 200;
    localparam logic [31:0] RANDOM_SEED = 32'he6d3_ee8f;

    logic                    clk;
    logic                    arst_n;
    logic [APB_ADDR_W  -1:0] paddr;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [APB_DATA_W  -1:0] pwdata;
    logic [APB_DATA_W  -1:0] prdata;
    logic                    pready;
    logic                    pslverr;
    logic [NUM_SWITCHES-1:0] sw;
    logic [NUM_BUTTONS -1:0] btn;
    logic [15:0]             led;
    logic [6:0]              seg;
    logic                    dp;
    logic [NUM_DIGITS  -1:0] an;

    int                      errors;
    int                      checks;
    logic [NUM_SWITCHES-1:0] sw_held;

    board_io_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // segment shapes g down to a, 1 means lit.
    function automatic logic [6:0] digit_shape(input logic [3:0] nibble);
        case (nibble)
            4'h0:    return 7'b0111111;
            4'h1:    return 7'b0000110;
            4'h2:    return 7'b1011011;
            4'h3:    return 7'b1001111;
            4'h4:    return 7'b1100110;
            4'h5:    return 7'b1101101;
            4'h6:    return 7'b1111101;
            4'h7:    return 7'b0000111;
            4'h8:    return 7'b1111111;
            4'h9:    return 7'b1101111;
            4'hA:    return 7'b1110111;
            4'hB:    return 7'b1111100;
            4'hC:    return 7'b0111001;
            4'hD:    return 7'b1011110;
            4'hE:    return 7'b1111001;
            default: return 7'b1110001;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected)
        else begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic note_failure(input string msg);
        $display("ERROR: %s", msg);
        errors++;
    endtask

    // setup cycle, then one access cycle since pready is always high.
    task automatic apb_transfer(input logic write, input logic [APB_ADDR_W-1:0] addr,
                                input logic [APB_DATA_W-1:0] wdata,
                                output logic [APB_DATA_W-1:0] rdata, output logic err);
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= write;
        pwdata  <= wdata;
        psel    <= 1'b1;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [APB_ADDR_W-1:0] addr,
                             input logic [APB_DATA_W-1:0] data, output logic err);
        logic [APB_DATA_W-1:0] unused;
        apb_transfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [APB_ADDR_W-1:0] addr,
                            output logic [APB_DATA_W-1:0] data, output logic err);
        apb_transfer(1'b0, addr, '0, data, err);
    endtask

    task automatic watch_display(input string name, input logic raw, input logic [31:0] data,
                                 input logic [NUM_DIGITS-1:0] enabled);
        logic [NUM_DIGITS-1:0] seen;
        logic [NUM_DIGITS-1:0] should_light;
        logic [7:0]            expected;
        int                    d;
        seen = '0;
        for (d = 0; d < NUM_DIGITS; d++)
            should_light[d] = enabled[d] && !(raw && d >= 4);
        @(posedge clk);                                 // outputs are one register behind.
        repeat (NUM_DIGITS * SCAN_CYCLES) begin
            @(negedge clk);
            for (d = 0; d < NUM_DIGITS; d++) begin
                if (!an[d]) begin
                    seen[d] = 1'b1;
                    assert (should_light[d])
                    else note_failure($sformatf("%s: digit %0d lit while dark", name, d));
                    if (should_light[d]) begin
                        if (raw)
                            expected = ~data[8*d +: 8];
                        else
                            expected = {1'b1, ~digit_shape(data[4*d +: 4])};
                        check_value($sformatf("%s %0d", name, d), 32'(expected), 32'({dp, seg}));
                    end
                end
            end
        end
        for (d = 0; d < NUM_DIGITS; d++) begin
            assert (seen[d] || !should_light[d])
            else note_failure($sformatf("%s: digit %0d never lit", name, d));
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        logic [31:0] rdata;
        logic [31:0] value;
        logic [31:0] disp;
        logic        err;
        int          bit_idx;
        int          b;
        errors  = 0;
        checks  = 0;
        void'($urandom(RANDOM_SEED));
        arst_n  = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        sw      = '0;
        btn     = '0;
        sw_held = '0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        // debounced switches, then a glitch too short to pass.
        repeat (4) begin
            value = $urandom;
            @(posedge clk);
            sw      <= value[NUM_SWITCHES-1:0];
            sw_held  = value[NUM_SWITCHES-1:0];
            repeat (HOLD_CYCLES) @(posedge clk);
            apb_read(REG_SWITCHES, rdata, err);
            check_value("switch read", 32'(sw_held), rdata);
            check_value("switch read pslverr", 32'(0), 32'(err));
        end
        bit_idx = $urandom % NUM_SWITCHES;
        @(posedge clk);
        fork
            begin
                sw <= sw_held ^ (NUM_SWITCHES'(1) << bit_idx);
                repeat (DEBOUNCE_CYCLES - 2) @(posedge clk);
                sw <= sw_held;
            end
            repeat (3) begin                            // reads land while a leaked glitch shows.
                apb_read(REG_SWITCHES, rdata, err);
                check_value("switch during glitch", 32'(sw_held), rdata);
            end
        join
        repeat (HOLD_CYCLES) @(posedge clk);
        apb_read(REG_SWITCHES, rdata, err);
        check_value("switch glitch", 32'(sw_held), rdata);

        // button press latch.
        b = $urandom % NUM_BUTTONS;
        @(posedge clk);
        btn <= NUM_BUTTONS'(1) << b;
        repeat (HOLD_CYCLES) @(posedge clk);
        apb_read(REG_BUTTONS, rdata, err);
        check_value("button held", 32'(1) << b, rdata);
        @(posedge clk);
        btn <= '0;
        repeat (HOLD_CYCLES) @(posedge clk);
        apb_read(REG_BUTTONS, rdata, err);
        check_value("button released", 32'(0), rdata);
        apb_read(REG_PRESSED, rdata, err);
        check_value("press latched", 32'(1) << b, rdata);
        apb_write(REG_PRESSED, 32'h0, err);
        apb_read(REG_PRESSED, rdata, err);
        check_value("press after zero write", 32'(1) << b, rdata);
        apb_write(REG_PRESSED, 32'(1) << b, err);
        apb_read(REG_PRESSED, rdata, err);
        check_value("press cleared", 32'(0), rdata);

        // leds.
        repeat (4) begin
            value = $urandom;
            apb_write(REG_LEDS, value, err);
            @(negedge clk);
            check_value("led port", 32'(value[15:0]), 32'(led));
            apb_read(REG_LEDS, rdata, err);
            check_value("led read", 32'(value[15:0]), rdata);
        end

        // hex display, all digits and then a partial mask.
        disp = $urandom;
        apb_write(REG_DISP_DATA, disp, err);
        apb_read(REG_DISP_DATA, rdata, err);
        check_value("display data read", disp, rdata);
        watch_display("hex digit", 1'b0, disp, 8'hFF);
        apb_write(REG_DISP_CTRL, 32'h0000_A500, err);
        apb_read(REG_DISP_CTRL, rdata, err);
        check_value("display control read", 32'h0000_A500, rdata);
        watch_display("hex masked", 1'b0, disp, 8'hA5);

        // raw display.
        apb_write(REG_DISP_CTRL, 32'h0000_FF01, err);
        disp = $urandom;
        apb_write(REG_DISP_DATA, disp, err);
        watch_display("raw digit", 1'b1, disp, 8'hFF);

        // slave errors.
        apb_read(8'h18, rdata, err);
        check_value("unmapped read 18", 32'(1), 32'(err));
        apb_read(8'h40, rdata, err);
        check_value("unmapped read 40", 32'(1), 32'(err));
        apb_read(8'hFC, rdata, err);
        check_value("unmapped read fc", 32'(1), 32'(err));
        apb_write(REG_SWITCHES, ~32'(sw_held), err);
        check_value("switch write pslverr", 32'(1), 32'(err));
        apb_write(REG_BUTTONS, 32'h1F, err);
        check_value("button write pslverr", 32'(1), 32'(err));
        apb_read(REG_SWITCHES, rdata, err);
        check_value("switch after write", 32'(sw_held), rdata);

        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
design/board_io_pkg.sv
design/input_debouncer.sv
design/apb_io_regs.sv
design/seven_seg_scanner.sv
design/board_io_top.sv
testbench/board_io_assert.sv
testbench/board_io_tb.sv
